//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal \
		--top-module tb_sa_controller -f sa_controller.f -o tb_sim
	./obj_dir/tb_sim | tee sim.log
	grep -q "Simulation PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- common/sa_ctrl_pkg.sv
`default_nettype none

package sa_ctrl_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // controller state
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic [3:0] {
        S_IDLE        = 4'd0,
        S_WAIT_WEIGHT = 4'd1,
        S_LOAD        = 4'd2,
        S_WAIT_BRAM   = 4'd3,
        S_READY       = 4'd4,
        S_START       = 4'd5,
        S_WAIT_DRAIN  = 4'd6
    } sa_state_e;

    ////////////////////////////////////////////////////////////////////////////
    // counter widths and timing
    ////////////////////////////////////////////////////////////////////////////

    // input feature address and per-round input count
    localparam int FEATURE_ADDR_W = 16;
    // channel totals and accumulated channels
    localparam int CHANNEL_W      = 10;
    localparam int DRAIN_CNT_W    = 4;

    // cycles spent in S_READY
    localparam int READY_CYCLES = 3;
    // fixed part of the drain time
    localparam int DRAIN_BASE   = 6;

    // index of the last drain cycle for a given filter size
    function automatic logic [DRAIN_CNT_W-1:0] drain_last_count(input int filter_size);
        return DRAIN_CNT_W'(2 * (filter_size - 1) + DRAIN_BASE - 1);
    endfunction

endpackage

`default_nettype wire

//--- dv/sa_ctrl_input.txt
// filter_size total_channels inputs_per_round rom0 rom1 rom2 rom3 passes column_num
// all hex; rom word bits 27:24 adder enables, 23:16 transfer selects,
// 15:8 column counts, 7:0 filter selects, row 0 lowest in each field
// column_num is the packed column number after the first load phase
3 2 8 1E4DB1B A39DB27 5C6DB24 F1BDB39 2 D7
1 5 3 0125A06 9FF5A2A 6875A11 33C5A25 2 55
2 3 1 C4EBD12 2B1BD09 7D2BD26 E99BD14 2 7D
2 2 6 455DB1A 8A6DB06 12CDB29 B03DB15 1 D7
3 3 4 D785A22 0F05A18 A445A0A 5E15A1E 3 55
1 4 10 3A0BD31 6C7BD0C F5EBD2D 8B2BD13 1 7D

//--- dv/tb_sa_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_sa_controller
    import sa_ctrl_pkg::*;
();

    localparam int N_ROWS       = 4;
    localparam int N_COLS       = 4;
    localparam int MAX_FILTER   = 3;
    localparam int NUM_TESTS    = 6;
    localparam int VEC_W        = 9;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 40;
    // ready phase length and fixed drain part
    localparam int READY_LEN    = 3;
    localparam int DRAIN_FIXED  = 6;

    logic                      clk_i = 1'b0;
    logic                      sel_mux_tr_rst;
    logic                      general_rst_i;
    logic                      input_ready_i;
    logic                      weight_ready_i;
    logic                      bram_ready_i;
    logic [1:0]                filter_size_i;
    logic [CHANNEL_W-1:0]      total_channels_i;
    logic [FEATURE_ADDR_W-1:0] inputs_per_round_i;
    logic [27:0]               rom_data_i;
    logic [1:0]                rom_addr_o;
    logic                      rom_rd_o;
    logic                      rst_o;
    logic                      load_o;
    logic                      ready_o;
    logic                      start_op_o;
    logic                      feature_rd_o;
    logic                      layer_done_o;
    logic [FEATURE_ADDR_W-1:0] in_feature_addr_o;
    logic [7:0]                f_sel_o;
    logic [7:0]                number_of_columns_o;
    logic [7:0]                sel_mux_tr_o;
    logic [7:0]                column_num_o;
    logic [7:0]                row_num_o;
    logic [3:0]                en_adder_node_o;
    logic [3:0]                sel_mux_node_o;

    logic [27:0] rom [0:N_COLS-1];
    logic [31:0] vec [0:NUM_TESTS*VEC_W-1];
    logic [15:0] lfsr_state = 16'd63;
    int          checks = 0;
    int          errors = 0;
    int          failures = 0;
    int          wd_cycles = 0;

    // combinational signal ROM
    assign rom_data_i = rom[rom_addr_o];

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    sa_controller #(
        .N_ROWS     (N_ROWS),
        .N_COLS     (N_COLS),
        .MAX_FILTER (MAX_FILTER)
    ) dut (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .general_rst_i       (general_rst_i),
        .input_ready_i       (input_ready_i),
        .weight_ready_i      (weight_ready_i),
        .bram_ready_i        (bram_ready_i),
        .filter_size_i       (filter_size_i),
        .total_channels_i    (total_channels_i),
        .inputs_per_round_i  (inputs_per_round_i),
        .rom_data_i          (rom_data_i),
        .rom_addr_o          (rom_addr_o),
        .rom_rd_o            (rom_rd_o),
        .rst_o               (rst_o),
        .load_o              (load_o),
        .ready_o             (ready_o),
        .start_op_o          (start_op_o),
        .feature_rd_o        (feature_rd_o),
        .in_feature_addr_o   (in_feature_addr_o),
        .layer_done_o        (layer_done_o),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o),
        .column_num_o        (column_num_o),
        .row_num_o           (row_num_o),
        .sel_mux_node_o      (sel_mux_node_o)
    );

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    // galois lfsr, one bit per step
    function automatic logic next_random_bit();
        logic bit_out;
        bit_out    = lfsr_state[0];
        lfsr_state = (lfsr_state >> 1) ^ (bit_out ? 16'hB400 : 16'h0000);
        return bit_out;
    endfunction

    function automatic logic signal_level(input int which);
        return (which == 0) ? load_o : ready_o;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic note_failure(input string msg);
        failures++;
        $display("%0t: %s", $time, msg);
    endtask

    task automatic wait_for_signal(input int which, input string what);
        int n;
        n = 0;
        while (!signal_level(which) && n < WAIT_LIMIT) begin
            n++;
            @(negedge clk_i);
        end
        if (!signal_level(which)) begin
            note_failure($sformatf("%s did not rise within %0d cycles", what, WAIT_LIMIT));
        end
    endtask

    // ready input held low for up to three extra cycles
    task automatic raise_after_hold(input logic bram);
        int holds;
        holds = 0;
        while (holds < 3 && next_random_bit()) begin
            holds++;
        end
        repeat (holds) @(negedge clk_i);
        @(posedge clk_i);
        if (bram) begin
            bram_ready_i <= 1'b1;
        end else begin
            weight_ready_i <= 1'b1;
        end
        @(negedge clk_i);
    endtask

    task automatic check_idle_outputs();
        check_value("rst_o", 1, rst_o);
        check_value("load_o", 0, load_o);
        check_value("ready_o", 0, ready_o);
        check_value("start_op_o", 0, start_op_o);
        check_value("feature_rd_o", 0, feature_rd_o);
        check_value("rom_rd_o", 0, rom_rd_o);
        check_value("layer_done_o", 0, layer_done_o);
        check_value("in_feature_addr_o", 0, in_feature_addr_o);
        check_value("f_sel_o", 0, f_sel_o);
        check_value("number_of_columns_o", 0, number_of_columns_o);
        check_value("sel_mux_tr_o", 0, sel_mux_tr_o);
        check_value("en_adder_node_o", 0, en_adder_node_o);
        check_value("column_num_o", 0, column_num_o);
    endtask

    // rows numbered 1..filter size, repeating
    task automatic check_rows(input int fs);
        logic [1:0] exp_row;
        for (int i = 0; i < N_ROWS; i++) begin
            exp_row = 2'((i % fs) + 1);
            check_value($sformatf("row_num_o[%0d]", i), exp_row, row_num_o[2*i +: 2]);
            check_value($sformatf("sel_mux_node_o[%0d]", i), exp_row != fs, sel_mux_node_o[i]);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // one layer, all passes until layer done
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_layer(input int t, input int abort_at);
        int          base;
        int          fs;
        int          ipr;
        int          passes;
        int          k;
        int          n_start;
        int          n_drain;
        int          done_at;
        int          exp_start;
        logic        done;
        logic        direct;
        logic [31:0] exp_addr;
        base   = t * VEC_W;
        fs     = int'(vec[base]);
        ipr    = int'(vec[base + 2]);
        // odd tests find the weights already there
        direct = (t % 2) == 1;
        @(posedge clk_i);
        filter_size_i      <= vec[base][1:0];
        total_channels_i   <= vec[base + 1][CHANNEL_W-1:0];
        inputs_per_round_i <= vec[base + 2][FEATURE_ADDR_W-1:0];
        for (int w = 0; w < N_COLS; w++) begin
            rom[w] <= vec[base + 3 + w][27:0];
        end
        input_ready_i  <= 1'b1;
        weight_ready_i <= direct;
        @(negedge clk_i);
        check_rows(fs);
        passes = 0;
        done   = 1'b0;
        while (!done) begin
            if (passes == 0 && direct) begin
                @(negedge clk_i);
                check_value("load_o after idle", 1, load_o);
            end else begin
                raise_after_hold(1'b0);
            end
            wait_for_signal(0, "load_o");
            passes++;
            k = 0;
            while (load_o && k <= N_COLS) begin
                check_value("rom_addr_o", k, rom_addr_o);
                check_value("rom_rd_o", 1, rom_rd_o);
                k++;
                @(posedge clk_i);
                weight_ready_i <= 1'b0;
                @(negedge clk_i);
            end
            check_value("load_o cycles", N_COLS, k);
            // last word in the registers, transfer selects one word behind
            check_value("f_sel_o", vec[base + 6][7:0], f_sel_o);
            check_value("number_of_columns_o", vec[base + 6][15:8], number_of_columns_o);
            check_value("en_adder_node_o", vec[base + 6][27:24], en_adder_node_o);
            check_value("sel_mux_tr_o", vec[base + 5][23:16], sel_mux_tr_o);
            if (passes == 1) begin
                check_value("column_num_o", vec[base + 8], column_num_o);
            end
            raise_after_hold(1'b1);
            wait_for_signal(1, "ready_o");
            k = 0;
            while (ready_o && k <= READY_LEN) begin
                exp_addr = (k < ipr) ? k : ipr - 1;
                check_value("in_feature_addr_o", exp_addr, in_feature_addr_o);
                check_value("feature_rd_o", 1, feature_rd_o);
                k++;
                @(posedge clk_i);
                bram_ready_i <= 1'b0;
                @(negedge clk_i);
            end
            check_value("ready_o cycles", READY_LEN, k);
            n_start = 0;
            while (start_op_o && feature_rd_o && n_start < WAIT_LIMIT) begin
                exp_addr = (k < ipr) ? k : ipr - 1;
                check_value("in_feature_addr_o", exp_addr, in_feature_addr_o);
                if (passes == abort_at) begin
                    @(posedge clk_i);
                    general_rst_i <= 1'b1;
                    input_ready_i <= 1'b0;
                    @(negedge clk_i);
                    @(posedge clk_i);
                    general_rst_i <= 1'b0;
                    @(negedge clk_i);
                    check_value("rst_o", 1, rst_o);
                    check_value("start_op_o", 0, start_op_o);
                    return;
                end
                k++;
                n_start++;
                // input streams only through the first start cycle
                @(posedge clk_i);
                input_ready_i <= 1'b0;
                @(negedge clk_i);
            end
            exp_start = (ipr > 4) ? ipr - 3 : 1;
            if (passes == 1 && exp_start < 2) begin
                exp_start = 2;
            end
            check_value("start_op_o start cycles", exp_start, n_start);
            n_drain = 0;
            done_at = -1;
            while (start_op_o && n_drain < WAIT_LIMIT) begin
                check_value("feature_rd_o", 0, feature_rd_o);
                exp_addr = (n_drain == 0) ? ipr - 1 : 0;
                check_value("in_feature_addr_o", exp_addr, in_feature_addr_o);
                if (layer_done_o && done_at < 0) begin
                    done_at = n_drain;
                end
                n_drain++;
                @(negedge clk_i);
            end
            check_value("start_op_o drain cycles", 2 * (fs - 1) + DRAIN_FIXED, n_drain);
            if (done_at >= 0) begin
                done = 1'b1;
                check_value("layer_done_o cycle", n_drain - 1, done_at);
                check_value("rst_o", 1, rst_o);
            end else if (passes >= int'(vec[base + 7])) begin
                done = 1'b1;
                note_failure($sformatf("test %0d: no layer_done_o after %0d passes", t, passes));
            end
        end
        check_value("load phases", vec[base + 7], passes);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int total;
        int plen;
        sel_mux_tr_rst     = 1'b1;
        general_rst_i      = 1'b0;
        input_ready_i      = 1'b0;
        weight_ready_i     = 1'b0;
        bram_ready_i       = 1'b0;
        filter_size_i      = 2'd1;
        total_channels_i   = '0;
        inputs_per_round_i = '0;
        for (int w = 0; w < N_COLS; w++) begin
            rom[w] = '0;
        end
        $readmemh("dv/sa_ctrl_input.txt", vec);
        @(negedge clk_i);
        @(negedge clk_i);
        check_idle_outputs();
        repeat (RESET_CYCLES - 2) @(posedge clk_i);
        sel_mux_tr_rst <= 1'b0;
        @(negedge clk_i);
        check_idle_outputs();
        if ($isunknown(vec[NUM_TESTS*VEC_W-1])) begin
            note_failure("test vector file is missing or short");
        end else begin
            // worst case per pass, abort run repeats test 0
            total = RESET_CYCLES;
            for (int t = 0; t < NUM_TESTS; t++) begin
                plen  = 30 + 2 * (int'(vec[t*VEC_W]) - 1);
                plen += (vec[t*VEC_W + 2] > 4) ? int'(vec[t*VEC_W + 2]) - 3 : 1;
                total += plen * int'(vec[t*VEC_W + 7]) * ((t == 0) ? 2 : 1);
            end
            wd_cycles = total * 4;
            run_layer(0, 2);
            for (int t = 0; t < NUM_TESTS; t++) begin
                run_layer(t, 0);
            end
        end
        $display("checks %0d, value errors %0d, other failures %0d", checks, errors, failures);
        if (errors == 0 && failures == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk_i);
        $display("watchdog expired after %0d cycles, the tests did not finish", wd_cycles);
        $display("checks %0d, value errors %0d, other failures %0d", checks, errors, failures + 1);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/sa_controller.sv
`timescale 1ns/1ps
`default_nettype none

module sa_controller
    import sa_ctrl_pkg::*;
#(
    parameter int N_ROWS     = 4,
    parameter int N_COLS     = 4,
    parameter int MAX_FILTER = 3,
    localparam int SEL_W  = $clog2(MAX_FILTER),
    localparam int COL_W  = $clog2(MAX_FILTER + 1),
    localparam int TR_W   = $clog2(N_COLS),
    localparam int LOAD_W = $clog2(N_COLS),
    localparam int ROM_W  = N_ROWS * (SEL_W + COL_W + TR_W + 1)
) (
    input  wire                           clk_i,
    input  wire                           sel_mux_tr_rst,
    input  wire                           general_rst_i,
    input  wire                           input_ready_i,
    input  wire                           weight_ready_i,
    input  wire                           bram_ready_i,
    input  wire  [COL_W-1:0]              filter_size_i,
    input  wire  [CHANNEL_W-1:0]          total_channels_i,
    input  wire  [FEATURE_ADDR_W-1:0]     inputs_per_round_i,
    input  wire  [ROM_W-1:0]              rom_data_i,
    output logic [LOAD_W-1:0]             rom_addr_o,
    output logic                          rom_rd_o,
    output logic                          rst_o,
    output logic                          load_o,
    output logic                          ready_o,
    output logic                          start_op_o,
    output logic                          feature_rd_o,
    output logic [FEATURE_ADDR_W-1:0]     in_feature_addr_o,
    output logic                          layer_done_o,
    output logic [N_ROWS-1:0][SEL_W-1:0]  f_sel_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  number_of_columns_o,
    output logic [N_ROWS-1:0][TR_W-1:0]   sel_mux_tr_o,
    output logic [N_ROWS-1:0]             en_adder_node_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  column_num_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  row_num_o,
    output logic [N_ROWS-1:0]             sel_mux_node_o
);

    sa_state_e state;
    logic      feature_last;

    // sequencer
    sa_ctrl_fsm #(
        .N_COLS     (N_COLS),
        .MAX_FILTER (MAX_FILTER)
    ) u_fsm (
        .clk_i          (clk_i),
        .sel_mux_tr_rst (sel_mux_tr_rst),
        .general_rst_i  (general_rst_i),
        .input_ready_i  (input_ready_i),
        .weight_ready_i (weight_ready_i),
        .bram_ready_i   (bram_ready_i),
        .filter_size_i  (filter_size_i),
        .feature_last_i (feature_last),
        .layer_done_i   (layer_done_o),
        .state_o        (state),
        .load_count_o   (rom_addr_o),
        .rst_o          (rst_o),
        .load_o         (load_o),
        .ready_o        (ready_o),
        .start_op_o     (start_op_o),
        .feature_rd_o   (feature_rd_o),
        .rom_rd_o       (rom_rd_o)
    );

    // feature address and channel passes
    layer_progress #(
        .N_ROWS     (N_ROWS),
        .MAX_FILTER (MAX_FILTER)
    ) u_progress (
        .clk_i              (clk_i),
        .sel_mux_tr_rst     (sel_mux_tr_rst),
        .state_i            (state),
        .filter_size_i      (filter_size_i),
        .total_channels_i   (total_channels_i),
        .inputs_per_round_i (inputs_per_round_i),
        .in_feature_addr_o  (in_feature_addr_o),
        .feature_last_o     (feature_last),
        .layer_done_o       (layer_done_o)
    );

    // per-row array configuration
    row_config_regs #(
        .N_ROWS     (N_ROWS),
        .N_COLS     (N_COLS),
        .MAX_FILTER (MAX_FILTER)
    ) u_row_cfg (
        .clk_i               (clk_i),
        .sel_mux_tr_rst      (sel_mux_tr_rst),
        .state_i             (state),
        .rom_data_i          (rom_data_i),
        .filter_size_i       (filter_size_i),
        .f_sel_o             (f_sel_o),
        .number_of_columns_o (number_of_columns_o),
        .sel_mux_tr_o        (sel_mux_tr_o),
        .en_adder_node_o     (en_adder_node_o),
        .column_num_o        (column_num_o),
        .row_num_o           (row_num_o),
        .sel_mux_node_o      (sel_mux_node_o)
    );

endmodule

`default_nettype wire

//--- row_config/row_config_regs.sv
`timescale 1ns/1ps
`default_nettype none

module row_config_regs
    import sa_ctrl_pkg::*;
#(
    parameter int N_ROWS     = 4,
    parameter int N_COLS     = 4,
    parameter int MAX_FILTER = 3,
    localparam int SEL_W = $clog2(MAX_FILTER),
    localparam int COL_W = $clog2(MAX_FILTER + 1),
    localparam int TR_W  = $clog2(N_COLS),
    localparam int ROM_W = N_ROWS * (SEL_W + COL_W + TR_W + 1)
) (
    input  wire                           clk_i,
    input  wire                           sel_mux_tr_rst,
    input  wire sa_state_e                state_i,
    input  wire  [ROM_W-1:0]              rom_data_i,
    input  wire  [COL_W-1:0]              filter_size_i,
    output logic [N_ROWS-1:0][SEL_W-1:0]  f_sel_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  number_of_columns_o,
    output logic [N_ROWS-1:0][TR_W-1:0]   sel_mux_tr_o,
    output logic [N_ROWS-1:0]             en_adder_node_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  column_num_o,
    output logic [N_ROWS-1:0][COL_W-1:0]  row_num_o,
    output logic [N_ROWS-1:0]             sel_mux_node_o
);

    // field offsets in the ROM word, row 0 lowest
    localparam int COL_LO = N_ROWS * SEL_W;
    localparam int TR_LO  = COL_LO + N_ROWS * COL_W;
    localparam int EN_LO  = TR_LO + N_ROWS * TR_W;

    logic [N_ROWS-1:0][SEL_W-1:0] sel_f;
    logic [N_ROWS-1:0][COL_W-1:0] ncol_f;
    logic [N_ROWS-1:0][TR_W-1:0]  tr_f;
    logic [N_ROWS-1:0]            en_f;
    logic [N_ROWS-1:0][TR_W-1:0]  tr_q;
    logic [N_ROWS-1:0][COL_W-1:0] col_cnt;

    assign sel_f  = rom_data_i[COL_LO-1:0];
    assign ncol_f = rom_data_i[TR_LO-1:COL_LO];
    assign tr_f   = rom_data_i[EN_LO-1:TR_LO];
    assign en_f   = rom_data_i[ROM_W-1:EN_LO];

    ////////////////////////////////////////////////////////////////////////////
    // configuration registers
    ////////////////////////////////////////////////////////////////////////////

    // transfer selects run one word behind the others
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_q                <= '0;
            sel_mux_tr_o        <= '0;
        end else if (state_i == S_IDLE) begin
            f_sel_o             <= '0;
            number_of_columns_o <= '0;
            en_adder_node_o     <= '0;
            tr_q                <= '0;
            sel_mux_tr_o        <= '0;
        end else if (state_i == S_LOAD) begin
            f_sel_o             <= sel_f;
            number_of_columns_o <= ncol_f;
            en_adder_node_o     <= en_f;
            tr_q                <= tr_f;
            sel_mux_tr_o        <= tr_q;
        end
    end

    // column counters wrap per row
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (state_i == S_IDLE) begin
            col_cnt      <= '0;
            column_num_o <= '0;
        end else if (state_i == S_LOAD) begin
            for (int i = 0; i < N_ROWS; i++) begin
                column_num_o[i] <= ncol_f[i] - col_cnt[i];
                col_cnt[i]      <= (col_cnt[i] == ncol_f[i] - 1'b1) ? '0 : col_cnt[i] + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // row numbering
    ////////////////////////////////////////////////////////////////////////////

    // rows grouped by filter size, last row of a group ends the node chain
    always_comb begin
        logic [COL_W-1:0] idx;
        idx = '0;
        for (int i = 0; i < N_ROWS; i++) begin
            if (idx == filter_size_i) begin
                idx = '0;
            end
            row_num_o[i]      = idx + 1'b1;
            sel_mux_node_o[i] = (idx + 1'b1) != filter_size_i;
            idx               = idx + 1'b1;
        end
    end

    for (genvar g = 0; g < N_ROWS; g++) begin : g_col_chk
        a_ncol_range: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
            state_i == S_LOAD |-> int'(ncol_f[g]) <= MAX_FILTER);
    end

endmodule

`default_nettype wire

//--- sa_controller.f
common/sa_ctrl_pkg.sv
sequencer/sa_ctrl_fsm.sv
sequencer/layer_progress.sv
row_config/row_config_regs.sv
hdl/sa_controller.sv
dv/tb_sa_controller.sv

//--- sequencer/layer_progress.sv
`timescale 1ns/1ps
`default_nettype none

module layer_progress
    import sa_ctrl_pkg::*;
#(
    parameter int N_ROWS     = 4,
    parameter int MAX_FILTER = 3,
    localparam int COL_W = $clog2(MAX_FILTER + 1)
) (
    input  wire                       clk_i,
    input  wire                       sel_mux_tr_rst,
    input  wire sa_state_e            state_i,
    input  wire  [COL_W-1:0]          filter_size_i,
    input  wire  [CHANNEL_W-1:0]      total_channels_i,
    input  wire  [FEATURE_ADDR_W-1:0] inputs_per_round_i,
    output logic [FEATURE_ADDR_W-1:0] in_feature_addr_o,
    output logic                      feature_last_o,
    output logic                      layer_done_o
);

    logic [CHANNEL_W-1:0]   channel_acc;
    logic [DRAIN_CNT_W-1:0] drain_cnt;
    logic                   feature_run;

    assign feature_run    = state_i inside {S_READY, S_START};
    assign feature_last_o = in_feature_addr_o == inputs_per_round_i - 1'b1;

    // feature address holds at the last input of the round
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            in_feature_addr_o <= '0;
        end else if (!feature_run) begin
            in_feature_addr_o <= '0;
        end else if (!feature_last_o) begin
            in_feature_addr_o <= in_feature_addr_o + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // channel passes
    ////////////////////////////////////////////////////////////////////////////

    // drain position so the done pulse lands on the last drain cycle
    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            drain_cnt   <= '0;
            channel_acc <= '0;
        end else begin
            drain_cnt <= (state_i == S_WAIT_DRAIN) ? drain_cnt + 1'b1 : '0;
            if (state_i == S_IDLE) begin
                channel_acc <= '0;
            end else if (state_i == S_WAIT_DRAIN && drain_cnt == '0) begin
                // rows are shared by N_ROWS / filter size channels
                channel_acc <= channel_acc + CHANNEL_W'(N_ROWS / int'(filter_size_i));
            end
        end
    end

    assign layer_done_o = state_i == S_WAIT_DRAIN
                       && drain_cnt == drain_last_count(int'(filter_size_i))
                       && channel_acc >= total_channels_i;

    a_filter_size_nonzero: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        state_i == S_WAIT_DRAIN |-> filter_size_i != '0);

endmodule

`default_nettype wire

//--- sequencer/sa_ctrl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module sa_ctrl_fsm
    import sa_ctrl_pkg::*;
#(
    parameter int N_COLS     = 4,
    parameter int MAX_FILTER = 3,
    localparam int LOAD_W = $clog2(N_COLS),
    localparam int COL_W  = $clog2(MAX_FILTER + 1)
) (
    input  wire               clk_i,
    input  wire               sel_mux_tr_rst,
    input  wire               general_rst_i,
    input  wire               input_ready_i,
    input  wire               weight_ready_i,
    input  wire               bram_ready_i,
    input  wire  [COL_W-1:0]  filter_size_i,
    input  wire               feature_last_i,
    input  wire               layer_done_i,
    output sa_state_e         state_o,
    output logic [LOAD_W-1:0] load_count_o,
    output logic              rst_o,
    output logic              load_o,
    output logic              ready_o,
    output logic              start_op_o,
    output logic              feature_rd_o,
    output logic              rom_rd_o
);

    localparam int READY_W = $clog2(READY_CYCLES);

    sa_state_e              state_q;
    sa_state_e              state_d;
    logic [LOAD_W-1:0]      load_cnt;
    logic [READY_W-1:0]     ready_cnt;
    logic [DRAIN_CNT_W-1:0] drain_cnt;
    logic                   load_last;
    logic                   ready_last;
    logic                   drain_last;

    assign load_last  = load_cnt == LOAD_W'(N_COLS - 1);
    assign ready_last = ready_cnt == READY_W'(READY_CYCLES - 1);
    assign drain_last = drain_cnt == drain_last_count(int'(filter_size_i));

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                if (input_ready_i && !general_rst_i) begin
                    state_d = weight_ready_i ? S_LOAD : S_WAIT_WEIGHT;
                end
            end
            S_WAIT_WEIGHT: begin
                if (weight_ready_i) begin
                    state_d = S_LOAD;
                end
            end
            // one ROM word per column
            S_LOAD: begin
                if (load_last) begin
                    state_d = S_WAIT_BRAM;
                end
            end
            S_WAIT_BRAM: begin
                if (bram_ready_i) begin
                    state_d = S_READY;
                end
            end
            S_READY: begin
                if (ready_last) begin
                    state_d = S_START;
                end
            end
            // stay while DRAM still streams features
            S_START: begin
                if (general_rst_i) begin
                    state_d = S_IDLE;
                end else if (feature_last_i && !input_ready_i) begin
                    state_d = S_WAIT_DRAIN;
                end
            end
            S_WAIT_DRAIN: begin
                if (general_rst_i) begin
                    state_d = S_IDLE;
                end else if (drain_last) begin
                    // next channel group needs fresh weights
                    state_d = layer_done_i ? S_IDLE : S_WAIT_WEIGHT;
                end
            end
            default: state_d = S_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // state register and phase counters
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i or posedge sel_mux_tr_rst) begin
        if (sel_mux_tr_rst) begin
            state_q   <= S_IDLE;
            load_cnt  <= '0;
            ready_cnt <= '0;
            drain_cnt <= '0;
        end else begin
            state_q   <= state_d;
            load_cnt  <= (state_q == S_LOAD && !load_last) ? load_cnt + 1'b1 : '0;
            ready_cnt <= (state_q == S_READY) ? ready_cnt + 1'b1 : '0;
            drain_cnt <= (state_q == S_WAIT_DRAIN) ? drain_cnt + 1'b1 : '0;
        end
    end

    assign state_o      = state_q;
    assign load_count_o = load_cnt;
    assign rst_o        = state_q == S_IDLE;
    assign load_o       = state_q == S_LOAD;
    assign rom_rd_o     = state_q == S_LOAD;
    assign ready_o      = state_q == S_READY;
    assign start_op_o   = state_q inside {S_START, S_WAIT_DRAIN};
    assign feature_rd_o = state_q inside {S_READY, S_START};

    // checks
    a_state_legal: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        state_q inside {S_IDLE, S_WAIT_WEIGHT, S_LOAD, S_WAIT_BRAM,
                        S_READY, S_START, S_WAIT_DRAIN});

    a_load_needs_weights: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        (state_q == S_LOAD && $past(state_q) != S_LOAD) |-> $past(weight_ready_i));

    a_load_cnt_range: assert property (@(posedge clk_i) disable iff (sel_mux_tr_rst)
        int'(load_cnt) < N_COLS);

endmodule

`default_nettype wire
